// File: floor_pkg.sv
/* Building geometry for an eleven-floor shaft. Floor 1 is index 0, so a
   floor index above TOP_FLOOR never names a real floor. */

package floor_pkg;

    //////////////////////////////////////////////////////////////////////
    // Shaft size
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_FLOORS = 11;
    localparam int FLOOR_BITS = 4;

    //////////////////////////////////////////////////////////////////////
    // Floor types
    //////////////////////////////////////////////////////////////////////

    // Floor index, floor 1 encoded as 0
    typedef logic [FLOOR_BITS-1:0] floor_t;

    // One request flag per floor, bit i is floor index i
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    // Highest valid floor index
    localparam floor_t TOP_FLOOR = floor_t'(NUM_FLOORS - 1);

endpackage

// File: cab_pkg.sv
/* Travel direction shared by the target scan and the cab control.
   The encoding matches the 1-bit direction line of the motion FSM. */

package cab_pkg;

    //////////////////////////////////////////////////////////////////////
    // Travel direction
    //////////////////////////////////////////////////////////////////////

    // Motion FSM reads 1 as up and 0 as down
    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } dir_t;

endpackage

// File: request_latch.sv
/* One bank of lit floor requests. All pressed buttons latch in the same cycle;
   a press at the current floor is ignored and that floor clears once stopped. */

`timescale 1ns/1ps

module request_latch (
    input  logic                   clock,
    input  logic                   reset_n,
    input  floor_pkg::floor_mask_t buttons,
    input  floor_pkg::floor_t      current_floor,
    input  logic                   power_on,
    input  logic                   emergency,
    input  logic                   moving,
    output floor_pkg::floor_mask_t lights
);

    logic                   enabled;
    floor_pkg::floor_mask_t here_mask;
    floor_pkg::floor_mask_t set_mask;
    floor_pkg::floor_mask_t clear_mask;

    // Buttons only count with power on and no emergency
    assign enabled = power_on && !emergency;

    // One-hot of the floor the cab stands at
    assign here_mask = floor_pkg::floor_mask_t'(1) << current_floor;

    assign set_mask   = enabled ? (buttons & ~here_mask) : '0;
    assign clear_mask = (enabled && !moving) ? here_mask : '0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else begin
            lights <= (lights | set_mask) & ~clear_mask;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // A light that turns on was pressed away from where the cab stood
    for (genvar i = 0; i < floor_pkg::NUM_FLOORS; i++) begin : g_no_set_here
        a_no_set_here : assert property (
            @(posedge clock) disable iff (!reset_n)
            $rose(lights[i]) |-> $past(current_floor) != floor_pkg::floor_t'(i)
        );
    end

endmodule

// File: target_selector.sv
/* Picks the next target from both request banks. A new target is loaded only
   while stopped at the previous one; with nothing pending the target holds. */

`timescale 1ns/1ps

module target_selector (
    input  logic                   clock,
    input  logic                   reset_n,
    input  floor_pkg::floor_mask_t call_lights,
    input  floor_pkg::floor_mask_t panel_lights,
    input  floor_pkg::floor_t      current_floor,
    input  logic                   moving,
    input  cab_pkg::dir_t          direction,
    output floor_pkg::floor_t      target_floor
);

    floor_pkg::floor_mask_t pending;
    floor_pkg::floor_mask_t above_mask;
    floor_pkg::floor_mask_t below_mask;
    floor_pkg::floor_mask_t pending_above;
    floor_pkg::floor_mask_t pending_below;
    floor_pkg::floor_t      scan_floor;
    logic                   scan_valid;
    logic                   reached;

    // Highest set bit of a mask, 0 when empty
    function automatic floor_pkg::floor_t highest_floor(input floor_pkg::floor_mask_t mask);
        floor_pkg::floor_t pick;
        pick = '0;
        for (int i = 0; i < floor_pkg::NUM_FLOORS; i++) begin
            if (mask[i]) begin
                pick = floor_pkg::floor_t'(i);
            end
        end
        return pick;
    endfunction

    // Lowest set bit of a mask, 0 when empty
    function automatic floor_pkg::floor_t lowest_floor(input floor_pkg::floor_mask_t mask);
        floor_pkg::floor_t pick;
        pick = '0;
        for (int i = floor_pkg::NUM_FLOORS - 1; i >= 0; i--) begin
            if (mask[i]) begin
                pick = floor_pkg::floor_t'(i);
            end
        end
        return pick;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Direction-priority scan
    //////////////////////////////////////////////////////////////////////

    assign pending = call_lights | panel_lights;

    always_comb begin
        for (int i = 0; i < floor_pkg::NUM_FLOORS; i++) begin
            above_mask[i] = floor_pkg::floor_t'(i) > current_floor;
            below_mask[i] = floor_pkg::floor_t'(i) < current_floor;
        end
    end

    assign pending_above = pending & above_mask;
    assign pending_below = pending & below_mask;

    // Keep going the current way, farthest request first, else turn around
    always_comb begin
        scan_valid = (|pending_above) || (|pending_below);
        if (direction == cab_pkg::DIR_UP) begin
            if (|pending_above) begin
                scan_floor = highest_floor(pending_above);
            end else begin
                scan_floor = highest_floor(pending_below);
            end
        end else begin
            if (|pending_below) begin
                scan_floor = lowest_floor(pending_below);
            end else begin
                scan_floor = lowest_floor(pending_above);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Target register
    //////////////////////////////////////////////////////////////////////

    assign reached = !moving && (target_floor == current_floor);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_floor <= '0;
        end else if (reached && scan_valid) begin
            target_floor <= scan_floor;
        end
    end

    a_target_in_shaft : assert property (
        @(posedge clock) disable iff (!reset_n)
        target_floor <= floor_pkg::TOP_FLOOR
    );

endmodule

// File: cab_control.sv
/* Start command, travel direction and door permissions for the motion FSM.
   Doors ignore the emergency button; they only need power and a stopped cab. */

`timescale 1ns/1ps

module cab_control (
    input  logic              clock,
    input  logic              reset_n,
    input  floor_pkg::floor_t target_floor,
    input  floor_pkg::floor_t current_floor,
    input  logic              moving,
    input  logic              power_on,
    input  logic              emergency,
    input  logic              door_open_btn,
    input  logic              door_close_btn,
    output logic              activate,
    output cab_pkg::dir_t     direction,
    output logic              door_open_allowed,
    output logic              door_close_allowed
);

    logic ready;
    logic doors_ok;

    // Stopped, powered and out of emergency
    assign ready    = power_on && !emergency && !moving;
    assign doors_ok = power_on && !moving;

    //////////////////////////////////////////////////////////////////////
    // Start and direction
    //////////////////////////////////////////////////////////////////////

    assign activate = ready && (target_floor != current_floor);

    // Holds the last travel direction when the cab is already at target
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            direction <= cab_pkg::DIR_UP;
        end else if (ready) begin
            if (target_floor > current_floor) begin
                direction <= cab_pkg::DIR_UP;
            end else if (target_floor < current_floor) begin
                direction <= cab_pkg::DIR_DOWN;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Door permissions
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= doors_ok && door_open_btn;
            door_close_allowed <= doors_ok && door_close_btn;
        end
    end

    // The cab only stops at its target, so leaving motion never brings a fresh start
    a_no_start_in_motion : assert property (
        @(posedge clock) disable iff (!reset_n)
        $past(moving) |-> !$rose(activate)
    );

endmodule

// File: floor_logic_control_unit.sv
/* Floor request controller for an eleven-floor car. Cab position, motion and
   travel direction come from the external motion FSM. */

`timescale 1ns/1ps

module floor_logic_control_unit (
    input  logic                   clock,
    input  logic                   reset_n,
    // Buttons, high while pressed
    input  floor_pkg::floor_mask_t floor_call_buttons,
    input  floor_pkg::floor_mask_t panel_buttons,
    input  logic                   door_open_btn,
    input  logic                   door_close_btn,
    input  logic                   emergency_btn,
    input  logic                   power_switch,
    // Status from the motion FSM
    input  floor_pkg::floor_t      current_floor_state,
    input  logic                   elevator_moving,
    input  cab_pkg::dir_t          elevator_direction,
    // Commands to the motion FSM
    output floor_pkg::floor_t      elevator_floor_selector,
    output cab_pkg::dir_t          direction_selector,
    output logic                   activate_elevator,
    // Button illumination
    output floor_pkg::floor_mask_t call_button_lights,
    output floor_pkg::floor_mask_t panel_button_lights,
    output logic                   door_open_allowed,
    output logic                   door_close_allowed
);

    //////////////////////////////////////////////////////////////////////
    // Request banks
    //////////////////////////////////////////////////////////////////////

    // Hall calls
    request_latch call_bank (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (floor_call_buttons),
        .current_floor (current_floor_state),
        .power_on      (power_switch),
        .emergency     (emergency_btn),
        .moving        (elevator_moving),
        .lights        (call_button_lights)
    );

    // Cab panel
    request_latch panel_bank (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (panel_buttons),
        .current_floor (current_floor_state),
        .power_on      (power_switch),
        .emergency     (emergency_btn),
        .moving        (elevator_moving),
        .lights        (panel_button_lights)
    );

    //////////////////////////////////////////////////////////////////////
    // Target and cab commands
    //////////////////////////////////////////////////////////////////////

    target_selector target_selector (
        .clock         (clock),
        .reset_n       (reset_n),
        .call_lights   (call_button_lights),
        .panel_lights  (panel_button_lights),
        .current_floor (current_floor_state),
        .moving        (elevator_moving),
        .direction     (elevator_direction),
        .target_floor  (elevator_floor_selector)
    );

    cab_control cab_control (
        .clock              (clock),
        .reset_n            (reset_n),
        .target_floor       (elevator_floor_selector),
        .current_floor      (current_floor_state),
        .moving             (elevator_moving),
        .power_on           (power_switch),
        .emergency          (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .activate           (activate_elevator),
        .direction          (direction_selector),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

// File: tb_model.svh
/* Reference rules of the floor request controller, included inside the testbench.
   Floors are plain integers 0 to TOP_FLOOR; -1 means no floor. */

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Lights of one bank after an edge
function automatic floor_pkg::floor_mask_t predict_lights(
    input floor_pkg::floor_mask_t lit,
    input floor_pkg::floor_mask_t pressed,
    input int                     here,
    input logic                   enabled,
    input logic                   moving
);
    floor_pkg::floor_mask_t result;
    result = lit;
    for (int f = 0; f < floor_pkg::NUM_FLOORS; f++) begin
        if (enabled && pressed[f] && f != here) begin
            result[f] = 1'b1;
        end
        if (enabled && !moving && f == here) begin
            result[f] = 1'b0;
        end
    end
    return result;
endfunction

// Farthest request on the preferred side, else the nearest one on the other side
function automatic int pick_target(
    input floor_pkg::floor_mask_t pending,
    input int                     here,
    input logic                   going_up
);
    int top;
    top = int'(floor_pkg::TOP_FLOOR);
    if (going_up) begin
        for (int f = top; f > here; f--) begin
            if (pending[f]) return f;
        end
        for (int f = here - 1; f >= 0; f--) begin
            if (pending[f]) return f;
        end
    end else begin
        for (int f = 0; f < here; f++) begin
            if (pending[f]) return f;
        end
        for (int f = here + 1; f <= top; f++) begin
            if (pending[f]) return f;
        end
    end
    return -1;
endfunction

// Start command seen after the edge
function automatic logic expect_activate(input logic ready, input int target, input int here);
    return ready && (target != here);
endfunction

// Direction register after an edge
function automatic cab_pkg::dir_t predict_direction(
    input cab_pkg::dir_t dir,
    input logic          ready,
    input int            target,
    input int            here
);
    if (ready && target > here) return cab_pkg::DIR_UP;
    if (ready && target < here) return cab_pkg::DIR_DOWN;
    return dir;
endfunction

`endif

// File: tb_floor_logic.sv
/* Testbench for the floor request controller. It plays the motion FSM, which starts
   two cycles after activate and needs three cycles per floor. */

`timescale 1ns/1ps

module tb_floor_logic;

    logic                   clock;
    logic                   reset_n;
    floor_pkg::floor_mask_t floor_call_buttons;
    floor_pkg::floor_mask_t panel_buttons;
    logic                   door_open_btn;
    logic                   door_close_btn;
    logic                   emergency_btn;
    logic                   power_switch;
    floor_pkg::floor_t      current_floor_state;
    logic                   elevator_moving;
    cab_pkg::dir_t          elevator_direction;
    floor_pkg::floor_t      elevator_floor_selector;
    cab_pkg::dir_t          direction_selector;
    logic                   activate_elevator;
    floor_pkg::floor_mask_t call_button_lights;
    floor_pkg::floor_mask_t panel_button_lights;
    logic                   door_open_allowed;
    logic                   door_close_allowed;

    // Motion FSM played here, and the shadow state of the DUT
    int                     cab_floor;
    int                     start_wait;
    int                     step_wait;
    floor_pkg::floor_mask_t exp_call;
    floor_pkg::floor_mask_t exp_panel;
    int                     exp_target;
    cab_pkg::dir_t          exp_dir;
    logic                   exp_door_open;
    logic                   exp_door_close;
    int                     error_count;

    `include "tb_model.svh"

    floor_logic_control_unit DUT (.*);

    initial clock = 1'b0;
    always #10 clock = ~clock;

    task automatic check_value(input string what, input int got, input int expected);
        assert (got == expected) else begin
            error_count++;
            $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
            $display("Result: FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    // One falling edge; the cab moves before any stimulus of this cycle
    task automatic tick();
        @(negedge clock);
        if (elevator_moving) begin
            if (step_wait > 1) begin
                step_wait--;
            end else begin
                cab_floor += (int'(elevator_floor_selector) > cab_floor) ? 1 : -1;
                current_floor_state = floor_pkg::floor_t'(cab_floor);
                elevator_moving = (cab_floor != int'(elevator_floor_selector));
                step_wait = 3;
            end
        end else if (start_wait > 0) begin
            start_wait--;
            elevator_moving = (start_wait == 0) && activate_elevator;
            step_wait = 3;
        end else if (activate_elevator) begin
            start_wait = 2;
        end
        elevator_direction = direction_selector;
    endtask

    task automatic press_buttons(input floor_pkg::floor_mask_t call,
                                 input floor_pkg::floor_mask_t panel);
        tick();
        floor_call_buttons = call;
        panel_buttons      = panel;
        tick();
        floor_call_buttons = '0;
        panel_buttons      = '0;
    endtask

    task automatic wait_until_idle(input int limit);
        int count;
        count = 0;
        while (elevator_moving || start_wait != 0 || activate_elevator ||
               (call_button_lights | panel_button_lights) != '0) begin
            if (count == limit) begin
                $display("Timeout: the cab did not serve every lit request in %0d cycles", limit);
                $display("Result: FAILED");
                $fatal(1, "Wait for idle timed out");
            end
            tick();
            count++;
        end
    endtask

    task automatic wait_for_motion(input int limit);
        int count;
        count = 0;
        while (!elevator_moving) begin
            if (count == limit) begin
                $display("Timeout: the cab never started moving toward its target");
                $display("Result: FAILED");
                $fatal(1, "Wait for motion timed out");
            end
            tick();
            count++;
        end
    endtask

    // Press from a stopped cab with no lit request, then check target, start and direction
    task automatic check_scan_start(input floor_pkg::floor_mask_t call,
                                    input floor_pkg::floor_mask_t panel);
        int expected;
        press_buttons(call, panel);
        expected = pick_target(call | panel, cab_floor,
                               elevator_direction == cab_pkg::DIR_UP);
        tick();
        check_value("scan target", int'(elevator_floor_selector), expected);
        check_value("activate at start", int'(activate_elevator), 1);
        tick();
        check_value("direction toward target", int'(direction_selector),
                    (expected > cab_floor) ? 1 : 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Shadow update at each rising edge, compare once outputs settle
    //////////////////////////////////////////////////////////////////////

    always begin : compare_outputs
        int   here;
        int   pick;
        logic ready;
        @(posedge clock);
        here  = int'(current_floor_state);
        ready = power_switch && !emergency_btn && !elevator_moving;
        if (!reset_n) begin
            exp_call       = '0;
            exp_panel      = '0;
            exp_target     = 0;
            exp_dir        = cab_pkg::DIR_UP;
            exp_door_open  = 1'b0;
            exp_door_close = 1'b0;
        end else begin
            // Direction and target see the state from before the edge
            exp_dir = predict_direction(exp_dir, ready, exp_target, here);
            if (!elevator_moving && exp_target == here) begin
                pick = pick_target(exp_call | exp_panel, here,
                                   elevator_direction == cab_pkg::DIR_UP);
                if (pick >= 0) begin
                    exp_target = pick;
                end
            end
            exp_call  = predict_lights(exp_call, floor_call_buttons, here,
                                       power_switch && !emergency_btn, elevator_moving);
            exp_panel = predict_lights(exp_panel, panel_buttons, here,
                                       power_switch && !emergency_btn, elevator_moving);
            exp_door_open  = power_switch && !elevator_moving && door_open_btn;
            exp_door_close = power_switch && !elevator_moving && door_close_btn;
        end
        #1;
        check_value("call lights", int'(call_button_lights), int'(exp_call));
        check_value("panel lights", int'(panel_button_lights), int'(exp_panel));
        check_value("target floor", int'(elevator_floor_selector), exp_target);
        check_value("direction", int'(direction_selector), int'(exp_dir));
        check_value("activate", int'(activate_elevator),
                    int'(expect_activate(ready, exp_target, here)));
        check_value("door open allowed", int'(door_open_allowed), int'(exp_door_open));
        check_value("door close allowed", int'(door_close_allowed), int'(exp_door_close));
    end

    initial begin
        void'($urandom(86));
        error_count         = 0;
        reset_n             = 1'b0;
        floor_call_buttons  = '0;
        panel_buttons       = '0;
        door_open_btn       = 1'b0;
        door_close_btn      = 1'b0;
        emergency_btn       = 1'b0;
        power_switch        = 1'b1;
        current_floor_state = '0;
        elevator_moving     = 1'b0;
        elevator_direction  = cab_pkg::DIR_UP;
        cab_floor           = 0;
        start_wait          = 0;
        step_wait           = 0;
        repeat (4) @(negedge clock);
        reset_n = 1'b1;

        // Presses without power or during an emergency stay dark
        power_switch = 1'b0;
        press_buttons(11'h000, 11'h080);
        check_value("panel light without power", int'(panel_button_lights), 0);
        power_switch  = 1'b1;
        emergency_btn = 1'b1;
        press_buttons(11'h100, 11'h000);
        check_value("call light in emergency", int'(call_button_lights), 0);
        emergency_btn = 1'b0;

        // Calls at floors 1 and 6, panel floor 4; floor 1 is where the cab stands
        press_buttons(11'h021, 11'h008);
        check_value("call lights after press", int'(call_button_lights), 'h020);
        check_value("panel lights after press", int'(panel_button_lights), 'h008);
        wait_until_idle(400);

        // Requests on both sides of the cab in both directions
        check_scan_start(11'h102, 11'h040);
        wait_until_idle(400);
        check_scan_start(11'h404, 11'h200);
        wait_until_idle(400);
        check_scan_start(11'h001, 11'h090);
        wait_until_idle(400);

        // Door permissions while stopped, without power, and in motion
        door_open_btn = 1'b1;
        tick();
        door_open_btn = 1'b0;
        check_value("door open while stopped", int'(door_open_allowed), 1);
        power_switch   = 1'b0;
        door_close_btn = 1'b1;
        tick();
        check_value("door close without power", int'(door_close_allowed), 0);
        power_switch   = 1'b1;
        door_close_btn = 1'b0;
        press_buttons('0, floor_pkg::floor_mask_t'(1) << ((cab_floor == 0) ? 10 : 0));
        wait_for_motion(20);
        door_open_btn = 1'b1;
        tick();
        door_open_btn = 1'b0;
        check_value("door open while moving", int'(door_open_allowed), 0);
        wait_until_idle(400);

        //////////////////////////////////////////////////////////////////////
        // Random run
        //////////////////////////////////////////////////////////////////////

        for (int cycle = 0; cycle < 2000; cycle++) begin
            tick();
            floor_call_buttons = '0;
            panel_buttons      = '0;
            if ($urandom_range(0, 7) == 0) begin
                floor_call_buttons = floor_pkg::floor_mask_t'(1) << $urandom_range(0, 10);
            end
            if ($urandom_range(0, 7) == 0) begin
                panel_buttons = floor_pkg::floor_mask_t'(1) << $urandom_range(0, 10);
            end
            power_switch   = ($urandom_range(0, 39) != 0);
            emergency_btn  = ($urandom_range(0, 49) == 0);
            door_open_btn  = ($urandom_range(0, 3) == 0);
            door_close_btn = ($urandom_range(0, 3) == 0);
        end
        tick();
        floor_call_buttons = '0;
        panel_buttons      = '0;
        power_switch       = 1'b1;
        emergency_btn      = 1'b0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        wait_until_idle(1000);

        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
floor_pkg.sv
cab_pkg.sv
request_latch.sv
target_selector.sv
cab_control.sv
floor_logic_control_unit.sv
tb_floor_logic.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tb_floor_logic -o tb_floor_logic > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_floor_logic > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
